// File: compile.f
logic/lc4_pkg.sv
logic/lc4_ifs.sv
logic/pair_dispatch.sv
logic/alu_lane.sv
logic/commit_regfile.sv
logic/lc4_superscalar.sv
tests/tb_lc4_superscalar.sv

// File: run_sim.sh
#!/bin/sh
# build and run the LC4 pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f compile.f \
   --top-module tb_lc4_superscalar -o tb_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "TESTBENCH PASSED" sim.log; then
   exit 0
fi
exit 1

// File: tests/tb_lc4_superscalar.sv
`timescale 1ns/1ps

module tb_lc4_superscalar;
   import lc4_pkg::*;

   localparam int CLK_PERIOD      = 4;
   localparam int RESET_CYCLES    = 8;
   localparam int MAX_ACK_DELAY   = 3;
   localparam int MEM_WORDS       = 64;
   localparam int TOTAL_PAIRS     = 52;
   localparam int NUM_PROGRAMS    = 6;
   localparam int WATCHDOG_CYCLES = TOTAL_PAIRS * (MAX_ACK_DELAY + 6) + NUM_PROGRAMS * 60;

   typedef struct packed {
      word_t    pc;
      word_t    insn;
      logic     we;
      reg_sel_t wsel;
      word_t    data;
      logic     split;
   } ret_rec_t;

   logic                         gwe    = 1'b0;
   logic                         rst_n  = 1'b0;
   logic                         wb_ack = 1'b0;
   logic [2*XLEN-1:0]            wb_dat = '0;
   logic                         wb_cyc;
   logic                         wb_stb;
   word_t                        wb_adr;
   logic [NUM_LANES-1:0]         ret_valid;
   word_t [NUM_LANES-1:0]        ret_pc;
   word_t [NUM_LANES-1:0]        ret_insn;
   logic [NUM_LANES-1:0]         ret_we;
   reg_sel_t [NUM_LANES-1:0]     ret_wsel;
   word_t [NUM_LANES-1:0]        ret_data;

   int       seed        = 32'hf01a_2da9;
   int       ack_delay   = 0;
   int       wait_cnt    = 0;
   logic     first_req   = 1'b1;
   logic     checking    = 1'b0;
   int       checks_done = 0;
   int       errors      = 0;
   word_t    prog [MEM_WORDS];
   int       prog_len;
   word_t    ref_rf [NUM_REGS];
   ret_rec_t exp_q [$];

   lc4_superscalar lc4_superscalar_i (
      .gwe         (gwe),
      .i_rst_n     (rst_n),
      .o_wb_cyc    (wb_cyc),
      .o_wb_stb    (wb_stb),
      .o_wb_adr    (wb_adr),
      .i_wb_dat    (wb_dat),
      .i_wb_ack    (wb_ack),
      .o_ret_valid (ret_valid),
      .o_ret_pc    (ret_pc),
      .o_ret_insn  (ret_insn),
      .o_ret_we    (ret_we),
      .o_ret_wsel  (ret_wsel),
      .o_ret_data  (ret_data)
   );

   initial begin
      forever #(CLK_PERIOD / 2) gwe = ~gwe;
   end

   task automatic compare_word(input string name, input word_t got, input word_t want);
      checks_done++;
      if (got !== want) begin
         errors++;
         $display("Fail %s: got %h, expected %h at %0t", name, got, want, $time);
      end
   endtask

   task automatic compare_sel(input string name, input reg_sel_t got, input reg_sel_t want);
      checks_done++;
      if (got !== want) begin
         errors++;
         $display("Fail %s: got %h, expected %h at %0t", name, got, want, $time);
      end
   endtask

   task automatic compare_flag(input string name, input logic got, input logic want);
      checks_done++;
      if (got !== want) begin
         errors++;
         $display("Fail %s: got %h, expected %h at %0t", name, got, want, $time);
      end
   endtask

   // words past the loaded program read as NOP
   function automatic word_t mem_word(word_t adr);
      word_t idx;
      idx = adr - RESET_PC;
      if (idx < word_t'(MEM_WORDS)) begin
         return prog[idx[5:0]];
      end
      return '0;
   endfunction

   // Wishbone classic slave, low half holds the even address
   always @(posedge gwe) begin
      if (!rst_n) begin
         wb_ack    <= 1'b0;
         wait_cnt  <= 0;
         first_req <= 1'b1;
      end else if (wb_ack) begin
         wb_ack    <= 1'b0;
         wait_cnt  <= 0;
         ack_delay <= int'($unsigned($random(seed)) % (MAX_ACK_DELAY + 1));
      end else if (wb_stb) begin
         if (first_req) begin
            compare_word("o_wb_adr", wb_adr, RESET_PC);
            first_req <= 1'b0;
         end
         if (wait_cnt == ack_delay) begin
            wb_ack <= 1'b1;
            wb_dat <= {mem_word(wb_adr + 16'd1), mem_word(wb_adr)};
         end else begin
            wait_cnt <= wait_cnt + 1;
         end
      end
   end

   function automatic word_t enc_rrr(logic [3:0] op, reg_sel_t d, reg_sel_t s,
                                     logic [2:0] sub, reg_sel_t t);
      return {op, d, s, sub, t};
   endfunction

   function automatic word_t enc_imm(logic [3:0] op, reg_sel_t d, reg_sel_t s, logic [4:0] imm);
      return {op, d, s, 1'b1, imm};
   endfunction

   function automatic word_t enc_const(reg_sel_t d, logic [8:0] imm);
      return {OP_CONST, d, imm};
   endfunction

   // register format reads rs and rt, NOT and immediates rs only
   function automatic logic reads_reg(word_t w, reg_sel_t r);
      if (w[15:12] != OP_ARITH && w[15:12] != OP_LOGIC) begin
         return 1'b0;
      end
      if (w[8:6] == r) begin
         return 1'b1;
      end
      return !w[5] && !(w[15:12] == OP_LOGIC && w[5:3] == SUB_NOT) && w[2:0] == r;
   endfunction

   task automatic model_exec(input word_t w, output logic we, output word_t val);
      word_t a;
      word_t b;
      word_t i5;
      a   = ref_rf[w[8:6]];
      b   = ref_rf[w[2:0]];
      i5  = {{11{w[4]}}, w[4:0]};
      we  = 1'b1;
      val = '0;
      if (w[15:12] == OP_ARITH) begin
         if (w[5]) val = a + i5;
         else if (w[5:3] == SUB_ADD) val = a + b;
         else if (w[5:3] == SUB_SUB) val = a - b;
         else we = 1'b0;
      end else if (w[15:12] == OP_LOGIC) begin
         if (w[5]) val = a & i5;
         else if (w[5:3] == SUB_AND) val = a & b;
         else if (w[5:3] == SUB_NOT) val = ~a;
         else if (w[5:3] == SUB_OR) val = a | b;
         else if (w[5:3] == SUB_XOR) val = a ^ b;
         else we = 1'b0;
      end else if (w[15:12] == OP_CONST) begin
         val = {{7{w[8]}}, w[8:0]};
      end else begin
         we = 1'b0;
      end
      if (we) begin
         ref_rf[w[11:9]] = val;
      end
   endtask

   // in-order model, slot A before slot B of each pair
   task automatic build_expected();
      ret_rec_t rec;
      logic     split;
      for (int r = 0; r < NUM_REGS; r++) begin
         ref_rf[r] = '0;
      end
      exp_q.delete();
      split = 1'b0;
      for (int i = 0; i < prog_len; i++) begin
         rec.pc   = RESET_PC + word_t'(i);
         rec.insn = prog[i];
         rec.wsel = prog[i][11:9];
         model_exec(prog[i], rec.we, rec.data);
         if (i % 2 == 0) begin
            split = rec.we && reads_reg(prog[i+1], prog[i][11:9]);
         end
         rec.split = split;
         exp_q.push_back(rec);
      end
   endtask

   task automatic check_retire(input int lane);
      ret_rec_t want;
      if (exp_q.size() == 0) begin
         compare_flag($sformatf("o_ret_we[%0d]", lane), ret_we[lane], 1'b0);
         return;
      end
      want = exp_q.pop_front();
      compare_word($sformatf("o_ret_pc[%0d]", lane), ret_pc[lane], want.pc);
      compare_word($sformatf("o_ret_insn[%0d]", lane), ret_insn[lane], want.insn);
      compare_flag($sformatf("o_ret_we[%0d]", lane), ret_we[lane], want.we);
      if (want.we) begin
         compare_sel($sformatf("o_ret_wsel[%0d]", lane), ret_wsel[lane], want.wsel);
         compare_word($sformatf("o_ret_data[%0d]", lane), ret_data[lane], want.data);
      end
      if (want.split && ret_valid[1-lane]) begin
         errors++;
         $display("Error: split pair at pc %h retired both lanes in one cycle", want.pc);
      end
   endtask

   always @(negedge gwe) begin
      if (checking) begin
         if (wb_cyc !== wb_stb) begin
            errors++;
            $display("Error: Wishbone cyc and stb differ at %0t", $time);
         end
         for (int l = 0; l < NUM_LANES; l++) begin
            if (ret_valid[l]) begin
               check_retire(l);
            end
         end
      end
   end

   task automatic check_idle();
      compare_flag("o_wb_cyc", wb_cyc, 1'b0);
      compare_flag("o_wb_stb", wb_stb, 1'b0);
      for (int l = 0; l < NUM_LANES; l++) begin
         compare_flag($sformatf("o_ret_valid[%0d]", l), ret_valid[l], 1'b0);
      end
   endtask

   task automatic reset_dut();
      @(posedge gwe);
      rst_n <= 1'b0;
      repeat (RESET_CYCLES - 1) @(posedge gwe);
      @(negedge gwe);
      check_idle();
      @(posedge gwe);
      rst_n <= 1'b1;
      // first cycle out of reset is still quiet
      @(negedge gwe);
      check_idle();
   endtask

   task automatic clear_program();
      for (int i = 0; i < MEM_WORDS; i++) begin
         prog[i] = '0;
      end
      prog_len = 0;
   endtask

   task automatic add_insn(input word_t w);
      prog[prog_len] = w;
      prog_len++;
   endtask

   task automatic execute_program(input string name);
      int limit;
      int waited;
      checking = 1'b0;
      if (prog_len % 2 != 0) begin
         prog_len++;
      end
      build_expected();
      reset_dut();
      checking = 1'b1;
      limit    = (prog_len / 2) * (MAX_ACK_DELAY + 6) + 20;
      waited   = 0;
      while (exp_q.size() != 0 && waited < limit) begin
         @(posedge gwe);
         waited++;
      end
      if (exp_q.size() != 0) begin
         errors++;
         $display("Error: %s left %0d instructions unretired", name, exp_q.size());
      end
      repeat (4) @(posedge gwe);
      checking = 1'b0;
      $display("%s: %0d instructions run", name, prog_len);
   endtask

   task automatic test_independent();
      clear_program();
      add_insn(enc_const(3'd1, 9'h1f0));
      add_insn(enc_const(3'd2, 9'd100));
      add_insn(enc_const(3'd3, 9'h0ff));
      add_insn(enc_const(3'd4, 9'h1ff));
      add_insn(enc_rrr(OP_ARITH, 3'd5, 3'd1, SUB_ADD, 3'd2));
      add_insn(enc_rrr(OP_ARITH, 3'd6, 3'd3, SUB_SUB, 3'd4));
      add_insn(enc_rrr(OP_LOGIC, 3'd7, 3'd3, SUB_AND, 3'd1));
      add_insn(enc_rrr(OP_LOGIC, 3'd0, 3'd2, SUB_OR, 3'd4));
      add_insn(enc_rrr(OP_LOGIC, 3'd5, 3'd1, SUB_XOR, 3'd3));
      add_insn(enc_rrr(OP_LOGIC, 3'd6, 3'd2, SUB_NOT, 3'd0));
      add_insn(enc_imm(OP_ARITH, 3'd7, 3'd1, 5'h1b));
      add_insn(enc_imm(OP_LOGIC, 3'd1, 3'd3, 5'h0f));
      add_insn(16'h0000);
      // compare opcode, retires without a write
      add_insn(16'h2a4b);
      execute_program("independent");
   endtask

   task automatic test_dependent();
      clear_program();
      add_insn(enc_const(3'd1, 9'd10));
      add_insn(enc_rrr(OP_ARITH, 3'd2, 3'd1, SUB_ADD, 3'd1));
      add_insn(enc_const(3'd3, 9'd5));
      add_insn(enc_rrr(OP_LOGIC, 3'd4, 3'd3, SUB_NOT, 3'd0));
      add_insn(enc_rrr(OP_ARITH, 3'd5, 3'd3, SUB_ADD, 3'd3));
      add_insn(enc_imm(OP_LOGIC, 3'd6, 3'd5, 5'h07));
      add_insn(enc_const(3'd0, 9'd4));
      add_insn(enc_rrr(OP_ARITH, 3'd1, 3'd2, SUB_SUB, 3'd3));
      execute_program("dependent");
   endtask

   task automatic test_bypass_chain();
      clear_program();
      add_insn(enc_const(3'd1, 9'd1));
      add_insn(enc_const(3'd2, 9'd2));
      add_insn(enc_rrr(OP_ARITH, 3'd3, 3'd1, SUB_ADD, 3'd2));
      add_insn(enc_rrr(OP_ARITH, 3'd4, 3'd2, SUB_ADD, 3'd2));
      add_insn(enc_rrr(OP_ARITH, 3'd5, 3'd3, SUB_ADD, 3'd4));
      add_insn(enc_rrr(OP_ARITH, 3'd6, 3'd4, SUB_SUB, 3'd3));
      add_insn(enc_rrr(OP_LOGIC, 3'd1, 3'd5, SUB_XOR, 3'd6));
      add_insn(enc_rrr(OP_LOGIC, 3'd2, 3'd5, SUB_OR, 3'd3));
      add_insn(enc_rrr(OP_ARITH, 3'd3, 3'd1, SUB_ADD, 3'd2));
      add_insn(enc_rrr(OP_LOGIC, 3'd4, 3'd1, SUB_NOT, 3'd0));
      execute_program("bypass chain");
   endtask

   task automatic test_same_dest();
      clear_program();
      add_insn(enc_const(3'd1, 9'd5));
      add_insn(enc_const(3'd1, 9'd7));
      add_insn(enc_rrr(OP_ARITH, 3'd2, 3'd1, SUB_ADD, 3'd1));
      add_insn(16'h0000);
      add_insn(enc_imm(OP_ARITH, 3'd3, 3'd0, 5'h01));
      add_insn(enc_imm(OP_ARITH, 3'd3, 3'd0, 5'h02));
      add_insn(enc_rrr(OP_ARITH, 3'd4, 3'd3, SUB_ADD, 3'd3));
      add_insn(16'h0000);
      execute_program("same destination");
   endtask

   // small register range so pairs collide often
   function automatic word_t random_insn();
      logic [31:0] bits;
      reg_sel_t    d;
      reg_sel_t    s;
      reg_sel_t    t;
      bits = $random(seed);
      d    = {1'b0, bits[1:0]};
      s    = {1'b0, bits[3:2]};
      t    = {1'b0, bits[5:4]};
      case (bits[19:16])
         4'd0, 4'd1: return enc_const(d, bits[14:6]);
         4'd2:       return enc_rrr(OP_ARITH, d, s, SUB_SUB, t);
         4'd3:       return enc_imm(OP_ARITH, d, s, bits[10:6]);
         4'd4:       return enc_rrr(OP_LOGIC, d, s, SUB_AND, t);
         4'd5:       return enc_rrr(OP_LOGIC, d, s, SUB_NOT, t);
         4'd6:       return enc_rrr(OP_LOGIC, d, s, SUB_OR, t);
         4'd7:       return enc_rrr(OP_LOGIC, d, s, SUB_XOR, t);
         4'd8:       return enc_imm(OP_LOGIC, d, s, bits[10:6]);
         4'd9:       return 16'h0000;
         default:    return enc_rrr(OP_ARITH, d, s, SUB_ADD, t);
      endcase
   endfunction

   task automatic test_random();
      repeat (2) begin
         clear_program();
         repeat (32) add_insn(random_insn());
         execute_program("random");
      end
   endtask

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Error: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
   end

   initial begin
      test_independent();
      test_dependent();
      test_bypass_chain();
      test_same_dest();
      test_random();
      $display("%0d checks, %0d errors", checks_done, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// File: logic/lc4_superscalar.sv
`timescale 1ns/1ps

module lc4_superscalar (
   input  logic                                          gwe,
   input  logic                                          i_rst_n,
   output logic                                          o_wb_cyc,
   output logic                                          o_wb_stb,
   output lc4_pkg::word_t                                o_wb_adr,
   input  logic [2*lc4_pkg::XLEN-1:0]                    i_wb_dat,
   input  logic                                          i_wb_ack,
   output logic [lc4_pkg::NUM_LANES-1:0]                 o_ret_valid,
   output lc4_pkg::word_t [lc4_pkg::NUM_LANES-1:0]       o_ret_pc,
   output lc4_pkg::word_t [lc4_pkg::NUM_LANES-1:0]       o_ret_insn,
   output logic [lc4_pkg::NUM_LANES-1:0]                 o_ret_we,
   output lc4_pkg::reg_sel_t [lc4_pkg::NUM_LANES-1:0]    o_ret_wsel,
   output lc4_pkg::word_t [lc4_pkg::NUM_LANES-1:0]       o_ret_data
);
   import lc4_pkg::*;

   issue_if   iss_if [NUM_LANES] ();
   result_if  res_if [NUM_LANES] ();
   regread_if rr_if ();

   pair_dispatch dispatch (
      .gwe      (gwe),
      .i_rst_n  (i_rst_n),
      .o_wb_cyc (o_wb_cyc),
      .o_wb_stb (o_wb_stb),
      .o_wb_adr (o_wb_adr),
      .i_wb_dat (i_wb_dat),
      .i_wb_ack (i_wb_ack),
      .lanes    (iss_if),
      .results  (res_if),
      .rd       (rr_if)
   );

   // lane 0 is slot A, lane 1 is slot B
   for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
      alu_lane lane (
         .gwe     (gwe),
         .i_rst_n (i_rst_n),
         .iss     (iss_if[g]),
         .res     (res_if[g])
      );
   end

   commit_regfile commit (
      .gwe         (gwe),
      .i_rst_n     (i_rst_n),
      .results     (res_if),
      .rd          (rr_if),
      .o_ret_valid (o_ret_valid),
      .o_ret_pc    (o_ret_pc),
      .o_ret_insn  (o_ret_insn),
      .o_ret_we    (o_ret_we),
      .o_ret_wsel  (o_ret_wsel),
      .o_ret_data  (o_ret_data)
   );

endmodule

// File: logic/commit_regfile.sv
`timescale 1ns/1ps

module commit_regfile (
   input  logic                                          gwe,
   input  logic                                          i_rst_n,
   result_if.sink                                        results [lc4_pkg::NUM_LANES],
   regread_if.slave                                      rd,
   output logic [lc4_pkg::NUM_LANES-1:0]                 o_ret_valid,
   output lc4_pkg::word_t [lc4_pkg::NUM_LANES-1:0]       o_ret_pc,
   output lc4_pkg::word_t [lc4_pkg::NUM_LANES-1:0]       o_ret_insn,
   output logic [lc4_pkg::NUM_LANES-1:0]                 o_ret_we,
   output lc4_pkg::reg_sel_t [lc4_pkg::NUM_LANES-1:0]    o_ret_wsel,
   output lc4_pkg::word_t [lc4_pkg::NUM_LANES-1:0]       o_ret_data
);
   import lc4_pkg::*;

   word_t                          rf [NUM_REGS];
   logic [NUM_LANES-1:0]           c_valid;
   logic [NUM_LANES-1:0]           c_we;
   word_t [NUM_LANES-1:0]          c_pc;
   word_t [NUM_LANES-1:0]          c_insn;
   reg_sel_t [NUM_LANES-1:0]       c_wsel;
   word_t [NUM_LANES-1:0]          c_data;

   for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
      assign c_valid[g] = results[g].valid;
      assign c_we[g]    = results[g].we;
      assign c_pc[g]    = results[g].pc;
      assign c_insn[g]  = results[g].insn;
      assign c_wsel[g]  = results[g].wsel;
      assign c_data[g]  = results[g].data;

      a_we_valid: assert property (@(posedge gwe) disable iff (!i_rst_n)
         results[g].we |-> results[g].valid);
   end

   // dispatch reads, bypass happens on its side
   for (genvar p = 0; p < 2*NUM_LANES; p++) begin : g_read
      assign rd.data[p] = rf[rd.sel[p]];
   end

   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         for (int r = 0; r < NUM_REGS; r++) begin
            rf[r] <= '0;
         end
         o_ret_valid <= '0;
         o_ret_we    <= '0;
      end else begin
         // later lane overrides, so B keeps a shared destination
         for (int l = 0; l < NUM_LANES; l++) begin
            if (c_we[l]) begin
               rf[c_wsel[l]] <= c_data[l];
            end
         end
         o_ret_valid <= c_valid;
         o_ret_we    <= c_we;
      end
   end

   // trace payload
   always_ff @(posedge gwe) begin
      o_ret_pc   <= c_pc;
      o_ret_insn <= c_insn;
      o_ret_wsel <= c_wsel;
      o_ret_data <= c_data;
   end

endmodule

// File: logic/alu_lane.sv
`timescale 1ns/1ps

module alu_lane (
   input  logic     gwe,
   input  logic     i_rst_n,
   issue_if.slave   iss,
   result_if.source res
);
   import lc4_pkg::*;

   logic  v_q;
   word_t pc_q;
   insn_u insn_q;
   word_t rs_q;
   word_t rt_q;
   word_t imm5_sext;
   word_t imm9_sext;
   word_t alu_out;
   logic  kept;

   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         v_q <= 1'b0;
      end else begin
         v_q <= iss.valid;
      end
   end

   always_ff @(posedge gwe) begin
      if (iss.valid) begin
         pc_q   <= iss.pc;
         insn_q <= iss.insn;
         rs_q   <= iss.rs_val;
         rt_q   <= iss.rt_val;
      end
   end

   assign imm5_sext = {{(XLEN-5){insn_q.rri.imm5[4]}}, insn_q.rri.imm5};
   assign imm9_sext = {{(XLEN-9){insn_q[8]}}, insn_q[8:0]};

   always_comb begin
      kept    = 1'b1;
      alu_out = '0;
      case (insn_q.rrr.opcode)
         OP_ARITH: begin
            if (insn_q.rri.is_imm) begin
               alu_out = rs_q + imm5_sext;
            end else begin
               case (insn_q.rrr.subop)
                  SUB_ADD: alu_out = rs_q + rt_q;
                  SUB_SUB: alu_out = rs_q - rt_q;
                  // MUL and DIV are not built
                  default: kept = 1'b0;
               endcase
            end
         end
         OP_LOGIC: begin
            if (insn_q.rri.is_imm) begin
               alu_out = rs_q & imm5_sext;
            end else begin
               case (insn_q.rrr.subop)
                  SUB_AND: alu_out = rs_q & rt_q;
                  SUB_NOT: alu_out = ~rs_q;
                  SUB_OR:  alu_out = rs_q | rt_q;
                  SUB_XOR: alu_out = rs_q ^ rt_q;
                  default: kept = 1'b0;
               endcase
            end
         end
         OP_CONST: alu_out = imm9_sext;
         // NOP and everything else retire without a write
         default:  kept = 1'b0;
      endcase
   end

   assign res.valid = v_q;
   assign res.pc    = pc_q;
   assign res.insn  = insn_q;
   assign res.we    = v_q && kept;
   assign res.wsel  = insn_q.rrr.rd;
   assign res.data  = alu_out;

   // a valid result carries a fully known instruction and pc
   a_res_known: assert property (@(posedge gwe) disable iff (!i_rst_n)
      res.valid |-> !$isunknown(res.insn) && !$isunknown(res.pc));

endmodule

// File: logic/pair_dispatch.sv
`timescale 1ns/1ps

module pair_dispatch (
   input  logic                       gwe,
   input  logic                       i_rst_n,
   output logic                       o_wb_cyc,
   output logic                       o_wb_stb,
   output lc4_pkg::word_t             o_wb_adr,
   input  logic [2*lc4_pkg::XLEN-1:0] i_wb_dat,
   input  logic                       i_wb_ack,
   issue_if.master                    lanes [lc4_pkg::NUM_LANES],
   result_if.monitor                  results [lc4_pkg::NUM_LANES],
   regread_if.master                  rd
);
   import lc4_pkg::*;

   word_t                fetch_pc;
   logic                 wb_req;
   word_t                pair_pc;
   insn_u                slot_insn [NUM_LANES];
   logic [NUM_LANES-1:0] slot_valid;
   logic [NUM_LANES-1:0] issue;
   logic                 dep_ab;
   logic                 drain;
   logic                 fetch_start;
   logic [NUM_LANES-1:0] res_wr;
   reg_sel_t             res_sel  [NUM_LANES];
   word_t                res_data [NUM_LANES];
   word_t                src_val  [2*NUM_LANES];

   function automatic logic writes_rd(insn_u insn);
      return insn.rrr.opcode inside {OP_ARITH, OP_LOGIC, OP_CONST};
   endfunction

   function automatic logic reads_rs(insn_u insn);
      return insn.rrr.opcode inside {OP_ARITH, OP_LOGIC};
   endfunction

   // NOT and the immediate forms have no rt
   function automatic logic reads_rt(insn_u insn);
      return reads_rs(insn) && !insn.rri.is_imm &&
             !(insn.rrr.opcode == OP_LOGIC && insn.rrr.subop == SUB_NOT);
   endfunction

   // split when B needs what A is about to produce
   assign dep_ab = writes_rd(slot_insn[0]) &&
                   ((reads_rs(slot_insn[1]) && slot_insn[0].rrr.rd == slot_insn[1].rrr.rs) ||
                    (reads_rt(slot_insn[1]) && slot_insn[0].rrr.rd == slot_insn[1].rrr.rt));

   assign issue[0]    = slot_valid[0];
   assign issue[1]    = slot_valid[1] && !(slot_valid[0] && dep_ab);
   assign drain       = (!slot_valid[0] || issue[0]) && (!slot_valid[1] || issue[1]);
   assign fetch_start = !wb_req && drain;

   assign o_wb_cyc = wb_req;
   assign o_wb_stb = wb_req;
   assign o_wb_adr = fetch_pc;

   for (genvar g = 0; g < NUM_LANES; g++) begin : g_slot
      assign res_wr[g]   = results[g].valid && results[g].we;
      assign res_sel[g]  = results[g].wsel;
      assign res_data[g] = results[g].data;

      assign rd.sel[2*g]   = slot_insn[g].rrr.rs;
      assign rd.sel[2*g+1] = slot_insn[g].rrr.rt;

      assign lanes[g].valid  = issue[g];
      assign lanes[g].pc     = pair_pc + word_t'(g);
      assign lanes[g].insn   = slot_insn[g];
      assign lanes[g].rs_val = src_val[2*g];
      assign lanes[g].rt_val = src_val[2*g+1];
   end

   // in-flight results override the register file, lane B last so it wins
   always_comb begin
      for (int i = 0; i < 2*NUM_LANES; i++) begin
         src_val[i] = rd.data[i];
         for (int l = 0; l < NUM_LANES; l++) begin
            if (res_wr[l] && res_sel[l] == rd.sel[i]) begin
               src_val[i] = res_data[l];
            end
         end
      end
   end

   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         fetch_pc   <= RESET_PC;
         wb_req     <= 1'b0;
         slot_valid <= '0;
      end else if (wb_req && i_wb_ack) begin
         wb_req     <= 1'b0;
         fetch_pc   <= fetch_pc + 16'd2;
         slot_valid <= '1;
      end else begin
         if (fetch_start) begin
            wb_req <= 1'b1;
         end
         slot_valid <= slot_valid & ~issue;
      end
   end

   // low half is the even address
   always_ff @(posedge gwe) begin
      if (wb_req && i_wb_ack) begin
         pair_pc      <= fetch_pc;
         slot_insn[0] <= i_wb_dat[XLEN-1:0];
         slot_insn[1] <= i_wb_dat[2*XLEN-1:XLEN];
      end
   end

   a_adr_stable: assert property (@(posedge gwe) disable iff (!i_rst_n)
      o_wb_stb && !i_wb_ack |=> o_wb_stb && $stable(o_wb_adr));

   // B alone only ever follows the A half of a split pair
   a_split_order: assert property (@(posedge gwe) disable iff (!i_rst_n)
      issue[1] && !issue[0] |-> $past(issue[0] && !issue[1]));

endmodule

// File: logic/lc4_ifs.sv
`timescale 1ns/1ps

// one issued instruction with its operands
interface issue_if;
   import lc4_pkg::*;

   logic  valid;
   word_t pc;
   insn_u insn;
   word_t rs_val;
   word_t rt_val;

   modport master (output valid, pc, insn, rs_val, rt_val);
   modport slave  (input  valid, pc, insn, rs_val, rt_val);
endinterface

// lane result on its way to commit
interface result_if;
   import lc4_pkg::*;

   logic     valid;
   word_t    pc;
   insn_u    insn;
   logic     we;
   reg_sel_t wsel;
   word_t    data;

   modport source  (output valid, pc, insn, we, wsel, data);
   modport sink    (input  valid, pc, insn, we, wsel, data);
   // bypass taps the same bundle
   modport monitor (input  valid, we, wsel, data);
endinterface

// rs and rt per slot, slot A in 0..1, slot B in 2..3
interface regread_if;
   import lc4_pkg::*;

   reg_sel_t sel  [2*NUM_LANES];
   word_t    data [2*NUM_LANES];

   modport master (output sel, input data);
   modport slave  (input sel, output data);
endinterface

// File: logic/lc4_pkg.sv
package lc4_pkg;

   localparam int XLEN      = 16;
   localparam int NUM_LANES = 2;
   localparam int NUM_REGS  = 8;

   // even, so every fetch lands on a pair boundary
   localparam logic [XLEN-1:0] RESET_PC = 16'h8200;

   // opcodes in insn[15:12]
   localparam logic [3:0] OP_NOP   = 4'h0;
   localparam logic [3:0] OP_ARITH = 4'h1;
   localparam logic [3:0] OP_LOGIC = 4'h5;
   localparam logic [3:0] OP_CONST = 4'h9;

   // sub-opcodes in insn[5:3], register format only
   localparam logic [2:0] SUB_ADD = 3'b000;
   localparam logic [2:0] SUB_SUB = 3'b010;
   localparam logic [2:0] SUB_AND = 3'b000;
   localparam logic [2:0] SUB_NOT = 3'b001;
   localparam logic [2:0] SUB_OR  = 3'b010;
   localparam logic [2:0] SUB_XOR = 3'b011;

   typedef logic [XLEN-1:0] word_t;
   typedef logic [2:0]      reg_sel_t;

   typedef struct packed {
      logic [3:0] opcode;
      reg_sel_t   rd;
      reg_sel_t   rs;
      logic [2:0] subop;
      reg_sel_t   rt;
   } insn_rrr_t;

   // CONST reads bits 8..0 of this view as imm9
   typedef struct packed {
      logic [3:0] opcode;
      reg_sel_t   rd;
      reg_sel_t   rs;
      logic       is_imm;
      logic [4:0] imm5;
   } insn_imm_t;

   typedef union packed {
      insn_rrr_t rrr;
      insn_imm_t rri;
   } insn_u;

endpackage
